/* armCtrlInput.txt */
# instr aluFlags stall flush | aluControlE branchTakenE (next cycle) | memWriteM memToRegM regWriteM pcSrcM flags (two cycles later)
# aluFlags feeds the instruction already in Execute; ff means don't care, driven random
# ADDS, CMP, conditional MOV
E2921001 ff 0 0  4 0  0 0 1 0 2
E3510000 02 0 0  a 0  0 0 0 0 4
03A03005 04 0 0  d 0  0 0 1 0 4
13A03005 ff 0 0  d 0  0 0 0 0 4
# BEQ taken, BNE not taken, MOV to R15
0A000002 ff 0 0  4 1  0 0 0 1 4
1A000002 ff 0 0  4 0  0 0 0 0 4
E1A0F000 ff 0 0  d 0  0 0 1 1 4
# STR up, LDR down
E5821004 ff 0 0  4 0  1 1 0 0 4
E5125004 ff 0 0  2 0  0 1 1 0 4
# SUBS held in Execute for two cycles
E2521001 ff 0 0  2 0  0 0 0 0 4
E2521001 01 1 0  2 0  0 0 0 0 4
E2521001 01 1 0  2 0  0 0 1 0 8
0C000000 08 0 0  0 0  0 0 0 0 8
# SUBS flushed on entry to Execute
E2521001 ff 0 1  0 0  0 0 0 0 8
0C000000 0f 0 0  0 0  0 0 0 0 8
# Z clear now
1A000002 ff 0 0  4 1  0 0 0 1 8
03A03005 ff 0 0  d 0  0 0 0 0 8
0C000000 ff 0 0  0 0  0 0 0 0 8
0C000000 ff 0 0  0 0  0 0 0 0 8
# CMP gives N and V, then BLT and BGE
E3510000 ff 0 0  a 0  0 0 0 0 9
0C000000 09 0 0  0 0  0 0 0 0 9
BA000002 ff 0 0  4 0  0 0 0 0 9
AA000002 ff 0 0  4 1  0 0 0 1 9
0C000000 ff 0 0  0 0  0 0 0 0 9
0C000000 ff 0 0  0 0  0 0 0 0 9

/* armCtrlPkg.sv */
package armCtrlPkg;

  // ==========================================================
  // Instruction word views
  // ==========================================================

  // Data processing layout
  typedef struct packed {
    logic [3:0]  cond;      // Condition field
    logic [1:0]  op;        // Instruction class
    logic        immBit;    // Immediate operand 2
    logic [3:0]  aluCmd;    // Data processing command
    logic        sBit;      // Set flags
    logic [3:0]  rn;        // First operand register
    logic [3:0]  rd;        // Destination register
    logic [11:0] operand2;  // Shifted reg or rotated imm
  } dpFieldsT;

  // Single word load/store layout
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immBit;    // Set means register offset
    logic        preIdx;    // Pre/post index
    logic        upBit;     // Add or subtract offset
    logic        byteBit;   // Byte access, unused here
    logic        writeBack; // Base writeback
    logic        loadBit;   // Load when set
    logic [3:0]  rn;        // Base register
    logic [3:0]  rd;        // Source/destination
    logic [11:0] offset12;
  } memFieldsT;

  // Same 32 bits, decoded per class
  typedef union packed {
    dpFieldsT  dpView;
    memFieldsT memView;
  } instrWordU;

  // ==========================================================
  // Control bundles
  // ==========================================================
  typedef struct packed {
    logic [1:0] regSrc;     // Register file read select
    logic [1:0] immSrc;     // Immediate extend select
    logic       aluSrc;     // ALU B from immediate
    logic       memToReg;   // Result from memory
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       flagWrite;  // S bit
    logic [3:0] aluControl;
    logic       pcWrite;    // Writes R15 or branches
    logic [3:0] cond;       // Carried to Execute for checking
  } decodeCtrlT;

  // Gated enables entering Memory
  typedef struct packed {
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic pcSrc;
  } memCtrlT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ==========================================================
  // Encodings
  // ==========================================================
  localparam logic [1:0] OpDataProc = 2'b00;
  localparam logic [1:0] OpMem      = 2'b01;
  localparam logic [1:0] OpBranch   = 2'b10;

  // ALU codes match the aluCmd field
  localparam logic [3:0] AluAnd = 4'b0000;
  localparam logic [3:0] AluEor = 4'b0001;
  localparam logic [3:0] AluSub = 4'b0010;
  localparam logic [3:0] AluAdd = 4'b0100;
  localparam logic [3:0] AluTst = 4'b1000;
  localparam logic [3:0] AluCmp = 4'b1010;
  localparam logic [3:0] AluOrr = 4'b1100;
  localparam logic [3:0] AluMov = 4'b1101;

  localparam logic [3:0] CondEq = 4'h0;
  localparam logic [3:0] CondNe = 4'h1;
  localparam logic [3:0] CondCs = 4'h2;
  localparam logic [3:0] CondCc = 4'h3;
  localparam logic [3:0] CondMi = 4'h4;
  localparam logic [3:0] CondPl = 4'h5;
  localparam logic [3:0] CondVs = 4'h6;
  localparam logic [3:0] CondVc = 4'h7;
  localparam logic [3:0] CondHi = 4'h8;
  localparam logic [3:0] CondLs = 4'h9;
  localparam logic [3:0] CondGe = 4'hA;
  localparam logic [3:0] CondLt = 4'hB;
  localparam logic [3:0] CondGt = 4'hC;
  localparam logic [3:0] CondLe = 4'hD;
  localparam logic [3:0] CondAl = 4'hE;

  localparam logic [3:0] PcRegIdx = 4'hF;  // R15

endpackage

/* armCtrlTop.sv */
`timescale 1ns/1ns

module armCtrlTop (
  input  logic              clk,
  input  logic              rstN,
  input  logic [31:0]       instrD,        // Raw word from fetch
  input  armCtrlPkg::flagsT aluFlagsE,
  input  logic              stallE,        // From hazard unit
  input  logic              flushE,
  output logic [1:0]        regSrcD,
  output logic [1:0]        immSrcD,
  output logic [3:0]        aluControlE,
  output logic              aluSrcE,
  output logic              branchTakenE,
  output logic              memWriteM,
  output logic              memToRegM,
  output logic              regWriteM,
  output logic              pcSrcM,
  output armCtrlPkg::flagsT flags,
  output logic              pcWrPending    // PC write somewhere in D, E or M
);

  armCtrlPkg::instrWordU  instrWordD;
  armCtrlPkg::decodeCtrlT ctrlD;
  armCtrlPkg::decodeCtrlT ctrlE;
  armCtrlPkg::memCtrlT    memCtrlE;
  armCtrlPkg::memCtrlT    memCtrlM;

  assign instrWordD = armCtrlPkg::instrWordU'(instrD);

  instrDecoder uDecoder (
    .instr (instrWordD),
    .ctrlD (ctrlD)
  );

  stageRegs uStageRegs (
    .clk      (clk),
    .rstN     (rstN),
    .stallE   (stallE),
    .flushE   (flushE),
    .ctrlD    (ctrlD),
    .memCtrlE (memCtrlE),
    .ctrlE    (ctrlE),
    .memCtrlM (memCtrlM)
  );

  condUnit uCondUnit (
    .clk          (clk),
    .rstN         (rstN),
    .stallE       (stallE),
    .ctrlE        (ctrlE),
    .aluFlagsE    (aluFlagsE),
    .memCtrlE     (memCtrlE),
    .branchTakenE (branchTakenE),
    .flags        (flags)
  );

  // ==========================================================
  // Outputs
  // ==========================================================
  assign regSrcD     = ctrlD.regSrc;     // Decode stage, same cycle
  assign immSrcD     = ctrlD.immSrc;
  assign aluControlE = ctrlE.aluControl;
  assign aluSrcE     = ctrlE.aluSrc;
  assign memWriteM   = memCtrlM.memWrite;
  assign memToRegM   = memCtrlM.memToReg;
  assign regWriteM   = memCtrlM.regWrite;
  assign pcSrcM      = memCtrlM.pcSrc;

  // Fetch waits while any stage may still redirect
  assign pcWrPending = ctrlD.pcWrite | ctrlE.pcWrite | memCtrlM.pcSrc;

endmodule

/* condUnit.sv */
`timescale 1ns/1ns

module condUnit (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   stallE,
  input  armCtrlPkg::decodeCtrlT ctrlE,
  input  armCtrlPkg::flagsT      aluFlagsE,     // From datapath ALU
  output armCtrlPkg::memCtrlT    memCtrlE,
  output logic                   branchTakenE,
  output armCtrlPkg::flagsT      flags          // Stored NZCV
);

  logic condEx;  // Condition passes

  // ==========================================================
  // Condition check
  // ==========================================================
  always_comb begin
    case (ctrlE.cond)
      armCtrlPkg::CondEq: condEx = flags.z;
      armCtrlPkg::CondNe: condEx = ~flags.z;
      armCtrlPkg::CondCs: condEx = flags.c;
      armCtrlPkg::CondCc: condEx = ~flags.c;
      armCtrlPkg::CondMi: condEx = flags.n;
      armCtrlPkg::CondPl: condEx = ~flags.n;
      armCtrlPkg::CondVs: condEx = flags.v;
      armCtrlPkg::CondVc: condEx = ~flags.v;
      armCtrlPkg::CondHi: condEx = flags.c & ~flags.z;            // Unsigned higher
      armCtrlPkg::CondLs: condEx = ~flags.c | flags.z;
      armCtrlPkg::CondGe: condEx = (flags.n == flags.v);         // Signed compare
      armCtrlPkg::CondLt: condEx = (flags.n != flags.v);
      armCtrlPkg::CondGt: condEx = ~flags.z & (flags.n == flags.v);
      armCtrlPkg::CondLe: condEx = flags.z | (flags.n != flags.v);
      armCtrlPkg::CondAl: condEx = 1'b1;
      default:            condEx = 1'b0;                         // 4'hF never
    endcase
  end

  // ==========================================================
  // Enable gating
  // ==========================================================
  always_comb begin
    memCtrlE.memWrite = ctrlE.memWrite & condEx;
    memCtrlE.memToReg = ctrlE.memToReg;   // Select only, no side effect
    memCtrlE.regWrite = ctrlE.regWrite & condEx;
    memCtrlE.pcSrc    = ctrlE.pcWrite & condEx;
  end

  assign branchTakenE = ctrlE.branch & condEx;

  // ==========================================================
  // Flags register
  // ==========================================================
  // Written at the end of Execute, so the next instruction in
  // Execute already tests the new value
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (!stallE && ctrlE.flagWrite && condEx) begin
      flags <= aluFlagsE;   // S bit set and condition passed
    end
  end

endmodule

/* filelist.f */
armCtrlPkg.sv
instrDecoder.sv
stageRegs.sv
condUnit.sv
armCtrlTop.sv
tbArmCtrl.sv

/* instrDecoder.sv */
`timescale 1ns/1ns

module instrDecoder (
  input  armCtrlPkg::instrWordU  instr,
  output armCtrlPkg::decodeCtrlT ctrlD
);

  logic dpWritesReg;  // Data processing result goes to Rd

  // ==========================================================
  // Data processing write-back rule
  // ==========================================================
  always_comb begin
    case (instr.dpView.aluCmd)
      armCtrlPkg::AluCmp,
      armCtrlPkg::AluTst: dpWritesReg = 1'b0;  // Flags only
      default:            dpWritesReg = 1'b1;  // Every other command writes Rd
    endcase
  end

  // ==========================================================
  // Main decode
  // ==========================================================
  always_comb begin
    ctrlD      = '0;
    ctrlD.cond = instr.dpView.cond;  // Same position in both views

    case (instr.dpView.op)
      armCtrlPkg::OpDataProc: begin
        ctrlD.regSrc     = 2'b00;
        ctrlD.immSrc     = 2'b00;                  // 8-bit rotated immediate
        ctrlD.aluSrc     = instr.dpView.immBit;    // Imm or register operand
        ctrlD.memToReg   = 1'b0;
        ctrlD.regWrite   = dpWritesReg;
        ctrlD.memWrite   = 1'b0;
        ctrlD.flagWrite  = instr.dpView.sBit;
        ctrlD.aluControl = instr.dpView.aluCmd;    // Command passes straight through
      end

      armCtrlPkg::OpMem: begin
        // Store reads Rd as write data
        ctrlD.regSrc   = instr.memView.loadBit ? 2'b00 : 2'b10;
        ctrlD.immSrc   = 2'b01;                    // 12-bit offset
        ctrlD.aluSrc   = ~instr.memView.immBit;    // I clear means immediate offset
        ctrlD.memToReg = 1'b1;
        ctrlD.regWrite = instr.memView.loadBit;
        ctrlD.memWrite = ~instr.memView.loadBit;
        // Offset direction
        ctrlD.aluControl = instr.memView.upBit ? armCtrlPkg::AluAdd
                                               : armCtrlPkg::AluSub;
      end

      armCtrlPkg::OpBranch: begin
        ctrlD.regSrc     = 2'b01;                  // Read PC as base
        ctrlD.immSrc     = 2'b10;                  // 24-bit word offset
        ctrlD.aluSrc     = 1'b1;
        ctrlD.branch     = 1'b1;
        ctrlD.aluControl = armCtrlPkg::AluAdd;     // PC plus offset
      end

      default: begin
        ctrlD = '0;                                // Unsupported class
      end
    endcase

    // Anything that redirects the PC
    ctrlD.pcWrite = ((instr.dpView.rd == armCtrlPkg::PcRegIdx) & ctrlD.regWrite)
                    | ctrlD.branch;
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the armCtrlTop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tbArmCtrl -o simArmCtrl

simOut=$(./obj_dir/simArmCtrl)
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

/* stageRegs.sv */
`timescale 1ns/1ns

module stageRegs (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   stallE,    // Hold Execute
  input  logic                   flushE,    // Kill entry into Execute
  input  armCtrlPkg::decodeCtrlT ctrlD,
  input  armCtrlPkg::memCtrlT    memCtrlE,  // Gated enables from condUnit
  output armCtrlPkg::decodeCtrlT ctrlE,
  output armCtrlPkg::memCtrlT    memCtrlM
);

  // ==========================================================
  // Decode to Execute
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlE <= '0;
    end else if (flushE) begin
      ctrlE <= '0;        // Flush beats stall
    end else if (!stallE) begin
      ctrlE <= ctrlD;
    end
    // Stalled, hold current instruction
  end

  // ==========================================================
  // Execute to Memory
  // ==========================================================
  // A held instruction must not issue its writes every cycle,
  // so Memory sees empty slots until Execute moves on
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memCtrlM <= '0;
    end else if (stallE) begin
      memCtrlM <= '0;     // Bubble
    end else begin
      memCtrlM <= memCtrlE;
    end
  end

endmodule

/* tbArmCtrl.sv */
`timescale 1ns/1ns

module tbArmCtrl;

  localparam int          ClkPeriod   = 100;
  localparam int          DriveDelay  = 10;            // Inputs change after the edge
  localparam int          SampleDelay = 40;            // Sample mid-cycle
  localparam int          ResetCycles = 3;
  localparam int          MaxVec      = 64;
  localparam int          FieldCount  = 11;            // Columns per vector line
  localparam logic [31:0] IdleInstr   = 32'h0C00_0000; // Op 2'b11, no controls
  localparam logic [31:0] RandSeed    = 32'h0da9_92bd;

  // Decode fields predicted from the raw word
  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       pcWrite;
  } decodeExpT;

  logic              clk;
  logic              rstN;
  logic [31:0]       instrD;
  armCtrlPkg::flagsT aluFlagsE;
  logic              stallE;
  logic              flushE;
  logic [1:0]        regSrcD;
  logic [1:0]        immSrcD;
  logic [3:0]        aluControlE;
  logic              aluSrcE;
  logic              branchTakenE;
  logic              memWriteM;
  logic              memToRegM;
  logic              regWriteM;
  logic              pcSrcM;
  armCtrlPkg::flagsT flags;
  logic              pcWrPending;

  // Vector table, stimulus then expected values
  logic [31:0] vecInstr    [MaxVec];
  logic [7:0]  vecFlagsIn  [MaxVec];  // 8'hff means random
  logic        vecStall    [MaxVec];
  logic        vecFlush    [MaxVec];
  logic [3:0]  expAluCtl   [MaxVec];  // Execute, one cycle later
  logic        expBranch   [MaxVec];
  logic        expMemWr    [MaxVec];  // Memory, two cycles later
  logic        expMemToReg [MaxVec];
  logic        expRegWr    [MaxVec];
  logic        expPcSrc    [MaxVec];
  logic [3:0]  expFlags    [MaxVec];

  decodeExpT expE;                    // Model of the Execute register

  int   vecCount;
  int   valueErrors;
  int   otherErrors;
  int   checkCount;
  int   cycleNo;
  logic loadDone;

  armCtrlTop u_dut (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .stallE       (stallE),
    .flushE       (flushE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .memToRegM    (memToRegM),
    .regWriteM    (regWriteM),
    .pcSrcM       (pcSrcM),
    .flags        (flags),
    .pcWrPending  (pcWrPending)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      valueErrors++;
      $display("ERROR %s: expected 0x%0h, actual 0x%0h at cycle %0d",
               name, expected, actual, cycleNo);
    end
  endtask

  // Source selects and PC redirect from the ARM encoding
  function automatic decodeExpT refDecode(input logic [31:0] word);
    decodeExpT res;
    logic      writesRd;
    res      = '0;
    writesRd = (word[24:21] != 4'b1000) && (word[24:21] != 4'b1010);  // TST and CMP
    case (word[27:26])
      2'b00: begin
        res.aluSrc  = word[25];                            // I set, rotated immediate
        res.pcWrite = writesRd && (word[15:12] == 4'hF);
      end
      2'b01: begin
        res.regSrc  = word[20] ? 2'b00 : 2'b10;            // STR reads Rd
        res.immSrc  = 2'b01;
        res.aluSrc  = ~word[25];
        res.pcWrite = word[20] && (word[15:12] == 4'hF);   // LDR into PC
      end
      2'b10: begin
        res.regSrc  = 2'b01;
        res.immSrc  = 2'b10;
        res.aluSrc  = 1'b1;
        res.pcWrite = 1'b1;
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  // Steps the Execute model with what the coming edge samples
  task automatic advanceExecuteModel();
    if (flushE) begin
      expE = '0;
    end else if (!stallE) begin
      expE = refDecode(instrD);
    end
  endtask

  task automatic loadVectors();
    int          fd;
    int          lineNo;
    int          fieldsRead;
    string       line;
    logic [31:0] fIn;
    logic [31:0] fFl;
    logic [31:0] fSt;
    logic [31:0] fFu;
    logic [31:0] fAlu;
    logic [31:0] fBr;
    logic [31:0] fMw;
    logic [31:0] fMr;
    logic [31:0] fRw;
    logic [31:0] fPc;
    logic [31:0] fFlags;
    lineNo = 0;
    fd = $fopen("armCtrlInput.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file armCtrlInput.txt");
      otherErrors++;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      lineNo++;
      if (line.len() < 2 || line.getc(0) == "#") continue;  // Comment or blank
      fieldsRead = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", fIn, fFl, fSt,
                           fFu, fAlu, fBr, fMw, fMr, fRw, fPc, fFlags);
      if (fieldsRead != FieldCount) begin
        $display("Short read on line %0d of the vector file, %0d of %0d fields",
                 lineNo, fieldsRead, FieldCount);
        otherErrors++;
        continue;
      end
      if (vecCount == MaxVec) begin
        $display("Vector file holds more than %0d vectors", MaxVec);
        otherErrors++;
        break;
      end
      vecInstr[vecCount]    = fIn;
      vecFlagsIn[vecCount]  = fFl[7:0];
      vecStall[vecCount]    = fSt[0];
      vecFlush[vecCount]    = fFu[0];
      expAluCtl[vecCount]   = fAlu[3:0];
      expBranch[vecCount]   = fBr[0];
      expMemWr[vecCount]    = fMw[0];
      expMemToReg[vecCount] = fMr[0];
      expRegWr[vecCount]    = fRw[0];
      expPcSrc[vecCount]    = fPc[0];
      expFlags[vecCount]    = fFlags[3:0];
      vecCount++;
    end
    $fclose(fd);
  endtask

  // Vector idx, or idle once the table runs out
  task automatic driveCycle(input int idx);
    logic [31:0] randBits;
    if (idx < vecCount) begin
      instrD = vecInstr[idx];
      stallE = vecStall[idx];
      flushE = vecFlush[idx];
      if (vecFlagsIn[idx] == 8'hff) begin
        randBits  = $urandom();            // No flag write this cycle
        aluFlagsE = armCtrlPkg::flagsT'(randBits[3:0]);
      end else begin
        aluFlagsE = armCtrlPkg::flagsT'(vecFlagsIn[idx][3:0]);
      end
    end else begin
      instrD    = IdleInstr;               // Drain the pipeline
      stallE    = 1'b0;
      flushE    = 1'b0;
      aluFlagsE = '0;
    end
  endtask

  task automatic checkOutputs(input int cyc);
    int        idx;
    decodeExpT expD;
    logic      expPcSrcM;
    // Decode outputs follow instrD, aluSrcE follows the Execute model
    expD = refDecode(instrD);
    compareValue("regSrcD", 32'(expD.regSrc), 32'(regSrcD));
    compareValue("immSrcD", 32'(expD.immSrc), 32'(immSrcD));
    compareValue("aluSrcE", 32'(expE.aluSrc), 32'(aluSrcE));
    if (cyc >= 2) begin
      expPcSrcM = expPcSrc[cyc - 2];
    end else begin
      expPcSrcM = 1'b0;                    // Memory still empty
    end
    compareValue("pcWrPending", 32'(expD.pcWrite | expE.pcWrite | expPcSrcM),
                 32'(pcWrPending));
    if (cyc >= 1 && cyc <= vecCount) begin
      idx = cyc - 1;                       // Execute latency
      compareValue("aluControlE", 32'(expAluCtl[idx]), 32'(aluControlE));
      compareValue("branchTakenE", 32'(expBranch[idx]), 32'(branchTakenE));
    end
    if (cyc >= 2 && cyc <= vecCount + 1) begin
      idx = cyc - 2;                       // Memory latency, flags too
      compareValue("memWriteM", 32'(expMemWr[idx]), 32'(memWriteM));
      compareValue("memToRegM", 32'(expMemToReg[idx]), 32'(memToRegM));
      compareValue("regWriteM", 32'(expRegWr[idx]), 32'(regWriteM));
      compareValue("pcSrcM", 32'(expPcSrc[idx]), 32'(pcSrcM));
      compareValue("flags", 32'(expFlags[idx]), 32'(flags));
    end
  endtask

  task automatic reportCounts();
    $display("%0d checks, %0d value errors, %0d other errors",
             checkCount, valueErrors, otherErrors);
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    clk         = 1'b0;
    rstN        = 1'b0;
    instrD      = IdleInstr;
    aluFlagsE   = '0;
    stallE      = 1'b0;
    flushE      = 1'b0;
    expE        = '0;
    vecCount    = 0;
    valueErrors = 0;
    otherErrors = 0;
    checkCount  = 0;
    cycleNo     = -1;                      // Reset phase
    loadDone    = 1'b0;
    void'($urandom(RandSeed));
    loadVectors();
    loadDone = 1'b1;

    repeat (ResetCycles) @(posedge clk);
    #(DriveDelay);
    rstN = 1'b1;
    #(SampleDelay);
    // Nothing enabled straight out of reset
    compareValue("memWriteM", 32'h0, 32'(memWriteM));
    compareValue("memToRegM", 32'h0, 32'(memToRegM));
    compareValue("regWriteM", 32'h0, 32'(regWriteM));
    compareValue("pcSrcM", 32'h0, 32'(pcSrcM));
    compareValue("branchTakenE", 32'h0, 32'(branchTakenE));
    compareValue("flags", 32'h0, 32'(flags));

    if (otherErrors == 0) begin
      for (int cyc = 0; cyc < vecCount + 2; cyc++) begin
        advanceExecuteModel();
        @(posedge clk);
        #(DriveDelay);
        cycleNo = cyc;
        driveCycle(cyc);
        #(SampleDelay);
        checkOutputs(cyc);
      end
    end

    reportCounts();
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    int watchdogNs;
    wait (loadDone);
    watchdogNs = (vecCount + 10) * ClkPeriod;
    #(watchdogNs);
    $display("Watchdog timeout, the run did not end within %0d ns", watchdogNs);
    otherErrors++;
    reportCounts();
    $display("Test failed");
    $finish;
  end

endmodule
